/* rtl/cpu_types_pkg.sv */
`default_nettype none

package cpu_types_pkg;

	// cpu-wide widths
	localparam int WORD_W = 32;
	localparam int ADDR_W = 32;

	// one instruction or data word
	typedef logic [WORD_W-1:0] word_t;

	// byte address, word aligned for fetch
	typedef logic [ADDR_W-1:0] addr_t;

	// fetch starts here out of reset
	localparam addr_t RESET_PC = '0;

endpackage

`default_nettype wire

/* rtl/cache_cfg_pkg.sv */
`default_nettype none

package cache_cfg_pkg;

	// direct-mapped, one word per frame
	localparam int ICACHE_FRAMES = 16;

	// address split: tag | index | byte offset
	localparam int IBYT_W = 2;
	localparam int IIDX_W = $clog2(ICACHE_FRAMES);
	localparam int ITAG_W = $bits(cpu_types_pkg::addr_t) - IIDX_W - IBYT_W;

	// field types
	typedef logic [ITAG_W-1:0] itag_t;
	typedef logic [IIDX_W-1:0] iidx_t;

	// backing ram depth in words
	localparam int MEM_WORDS = 1024;

	// cycles iwait stays up on a read
	localparam int MEM_LATENCY = 4;

	// icache controller states
	typedef enum logic {
		ACCESS,
		MISS
	} icache_state_t;

endpackage

`default_nettype wire

/* rtl/datapath_cache_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface datapath_cache_if;

	// request from the fetch unit, held until ihit
	logic imemREN;
	cpu_types_pkg::addr_t imemaddr;

	// answer from the icache
	// imemload belongs to imemaddr in the ihit cycle
	logic ihit;
	cpu_types_pkg::word_t imemload;

	modport datapath (
		output imemREN,
		output imemaddr,
		input ihit,
		input imemload
	);

	modport cache (
		input imemREN,
		input imemaddr,
		output ihit,
		output imemload
	);

endinterface

`default_nettype wire

/* rtl/caches_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface caches_if;

	// read request from the icache
	// iaddr steady while iREN is up
	logic iREN;
	cpu_types_pkg::addr_t iaddr;

	// memory side, iload valid once iwait drops
	logic iwait;
	cpu_types_pkg::word_t iload;

	modport cache (
		output iREN,
		output iaddr,
		input iwait,
		input iload
	);

	modport memory (
		input iREN,
		input iaddr,
		output iwait,
		output iload
	);

endinterface

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input logic CLK,
	input logic nRST,
	input logic fetch_en,
	input logic branch,
	input cpu_types_pkg::addr_t branch_target,
	datapath_cache_if.datapath dcif,
	output cpu_types_pkg::word_t instr,
	output cpu_types_pkg::addr_t instr_pc,
	output logic instr_valid
);

	cpu_types_pkg::addr_t pc;
	cpu_types_pkg::addr_t pc_next;
	cpu_types_pkg::addr_t target_al;
	cpu_types_pkg::addr_t redir_pc;
	logic req_q;
	logic redir_pend;
	logic take;

	// targets forced onto a word boundary
	assign target_al = branch_target & ~cpu_types_pkg::addr_t'(3);

	// outstanding request answered this cycle
	assign take = req_q && dcif.ihit;

	// request straight from the pc
	assign dcif.imemREN = req_q;
	assign dcif.imemaddr = pc;

	// next pc select
	always_comb begin
		pc_next = pc;
		if (branch && (take || !req_q)) begin
			// nothing in flight or it finishes now
			pc_next = target_al;
		end else if (take) begin
			if (redir_pend) begin
				pc_next = redir_pc;
			end else begin
				pc_next = pc + cpu_types_pkg::addr_t'(4);
			end
		end
	end

	// control state
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= cpu_types_pkg::RESET_PC;
			req_q <= 1'b0;
			redir_pend <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			pc <= pc_next;
			instr_valid <= take;
			// new request only once the old one is done
			if (take || !req_q) begin
				req_q <= fetch_en;
			end
			// branch during an unanswered request waits
			if (take) begin
				redir_pend <= 1'b0;
			end else if (branch && req_q) begin
				redir_pend <= 1'b1;
			end
		end
	end

	// redirect target and output word
	always_ff @(posedge CLK) begin
		if (branch) begin
			redir_pc <= target_al;
		end
		if (take) begin
			instr <= dcif.imemload;
			instr_pc <= pc;
		end
	end

	// fetch addresses always word aligned
	a_pc_aligned: assert property (@(posedge CLK) disable iff (!nRST)
		dcif.imemaddr[1:0] == 2'b00);

	// request held steady until the cache answers
	a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		dcif.imemREN && !dcif.ihit |=> dcif.imemREN && $stable(dcif.imemaddr));

endmodule

`default_nettype wire

/* rtl/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
	input logic CLK,
	input logic nRST,
	datapath_cache_if.cache dcif,
	caches_if.cache cif
);

	cache_cfg_pkg::icache_state_t state;
	cache_cfg_pkg::icache_state_t next_state;

	// frame storage
	logic [cache_cfg_pkg::ICACHE_FRAMES-1:0] valid;
	cache_cfg_pkg::itag_t tags [cache_cfg_pkg::ICACHE_FRAMES];
	cpu_types_pkg::word_t data [cache_cfg_pkg::ICACHE_FRAMES];

	// request fields
	cache_cfg_pkg::iidx_t idx;
	cache_cfg_pkg::itag_t tag;
	logic tag_hit;
	logic fill;

	// index above the byte offset, tag above the index
	assign idx = dcif.imemaddr[cache_cfg_pkg::IBYT_W +: cache_cfg_pkg::IIDX_W];
	assign tag = dcif.imemaddr[cache_cfg_pkg::IBYT_W + cache_cfg_pkg::IIDX_W
		+: cache_cfg_pkg::ITAG_W];

	// valid frame with matching tag
	assign tag_hit = valid[idx] && (tags[idx] == tag);

	// memory word arrives this cycle
	assign fill = (state == cache_cfg_pkg::MISS) && !cif.iwait;

	// hit answers combinationally, a fill answers with the memory word
	always_comb begin
		if (state == cache_cfg_pkg::ACCESS) begin
			dcif.ihit = dcif.imemREN && tag_hit;
		end else begin
			dcif.ihit = fill;
		end
	end

	// bypass the memory word during a fill
	assign dcif.imemload = fill ? cif.iload : data[idx];

	// memory read held for the whole miss
	assign cif.iREN = (state == cache_cfg_pkg::MISS);
	assign cif.iaddr = dcif.imemaddr;

	// access / miss sequencing
	always_comb begin
		next_state = state;
		case (state)
			cache_cfg_pkg::ACCESS: begin
				if (dcif.imemREN && !tag_hit) begin
					next_state = cache_cfg_pkg::MISS;
				end
			end
			cache_cfg_pkg::MISS: begin
				// back once the frame is filled
				if (!cif.iwait) begin
					next_state = cache_cfg_pkg::ACCESS;
				end
			end
			default: begin
				next_state = cache_cfg_pkg::ACCESS;
			end
		endcase
	end

	// state and valid bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= cache_cfg_pkg::ACCESS;
			valid <= '0;
		end else begin
			state <= next_state;
			if (fill) begin
				valid[idx] <= 1'b1;
			end
		end
	end

	// tag and word written on fill
	always_ff @(posedge CLK) begin
		if (fill) begin
			tags[idx] <= tag;
			data[idx] <= cif.iload;
		end
	end

	// no answer without a request from fetch
	a_hit_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
		dcif.ihit |-> dcif.imemREN);

	// fetch keeps its request up for the whole miss
	a_miss_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
		state == cache_cfg_pkg::MISS |-> dcif.imemREN);

endmodule

`default_nettype wire

/* rtl/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
	input logic CLK,
	input logic nRST,
	caches_if.memory cif,
	input logic load_en,
	input cpu_types_pkg::addr_t load_addr,
	input cpu_types_pkg::word_t load_data
);

	// word array
	cpu_types_pkg::word_t mem [cache_cfg_pkg::MEM_WORDS];

	// word indices, byte offset dropped
	logic [$clog2(cache_cfg_pkg::MEM_WORDS)-1:0] rd_idx;
	logic [$clog2(cache_cfg_pkg::MEM_WORDS)-1:0] wr_idx;

	// read latency counter, saturates at MEM_LATENCY
	logic [$clog2(cache_cfg_pkg::MEM_LATENCY + 1)-1:0] lat_cnt;

	assign rd_idx = cif.iaddr[cache_cfg_pkg::IBYT_W +: $clog2(cache_cfg_pkg::MEM_WORDS)];
	assign wr_idx = load_addr[cache_cfg_pkg::IBYT_W +: $clog2(cache_cfg_pkg::MEM_WORDS)];

	// program load port, visible next cycle
	always_ff @(posedge CLK) begin
		if (load_en) begin
			mem[wr_idx] <= load_data;
		end
	end

	// clears between reads, counts while one is pending
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lat_cnt <= '0;
		end else if (!cif.iREN) begin
			lat_cnt <= '0;
		end else if (cif.iwait) begin
			lat_cnt <= lat_cnt + 1'b1;
		end
	end

	// wait drops once the count is reached
	assign cif.iwait = (lat_cnt != cache_cfg_pkg::MEM_LATENCY);

	// asynchronous read at the held address
	assign cif.iload = mem[rd_idx];

	// cache keeps the read up on the same address until data returns
	a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
		cif.iREN && cif.iwait |=> cif.iREN && $stable(cif.iaddr));

endmodule

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input logic CLK,
	input logic nRST,
	input logic fetch_en,
	input logic branch,
	input cpu_types_pkg::addr_t branch_target,
	input logic load_en,
	input cpu_types_pkg::addr_t load_addr,
	input cpu_types_pkg::word_t load_data,
	output cpu_types_pkg::word_t instr,
	output cpu_types_pkg::addr_t instr_pc,
	output logic instr_valid
);

	// fetch unit to icache
	datapath_cache_if dcif ();

	// icache to instruction memory
	caches_if cif ();

	// pc stage and output register
	fetch_unit i_fetch_unit (
		.CLK(CLK),
		.nRST(nRST),
		.fetch_en(fetch_en),
		.branch(branch),
		.branch_target(branch_target),
		.dcif(dcif.datapath),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_valid(instr_valid)
	);

	// direct-mapped cache
	icache i_icache (
		.CLK(CLK),
		.nRST(nRST),
		.dcif(dcif.cache),
		.cif(cif.cache)
	);

	// backing ram with the load port
	instr_mem i_instr_mem (
		.CLK(CLK),
		.nRST(nRST),
		.cif(cif.memory),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

endmodule

`default_nettype wire

/* tests/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	// wait budget per delivered instruction, one miss plus slack
	localparam int WAIT_PER = 2 * cache_cfg_pkg::MEM_LATENCY + 8;

	// byte distance between two addresses sharing a frame
	localparam int SET_STRIDE = 1 << (cache_cfg_pkg::IIDX_W + cache_cfg_pkg::IBYT_W);

	logic CLK;
	logic nRST;
	logic fetch_en;
	logic branch;
	logic load_en;
	cpu_types_pkg::addr_t branch_target;
	cpu_types_pkg::addr_t load_addr;
	cpu_types_pkg::word_t load_data;
	cpu_types_pkg::word_t instr;
	cpu_types_pkg::addr_t instr_pc;
	logic instr_valid;

	// copy of the loaded program
	cpu_types_pkg::word_t prog [cache_cfg_pkg::MEM_WORDS];
	logic [31:0] lfsr_state = 32'h72fd;

	// counters shared with the test sequence
	int n_checks = 0;
	int n_err = 0;
	int n_valid = 0;
	int n_redir = 0;
	int cyc = 0;
	bit abort = 1'b0;
	string cur_test = "reset";

	// expected pc stream
	cpu_types_pkg::addr_t exp_pc = cpu_types_pkg::RESET_PC;
	cpu_types_pkg::addr_t pend_target;
	bit pend = 1'b0;
	bit tgt_next = 1'b0;

	fetch_top i_fetch_top (
		.CLK(CLK),
		.nRST(nRST),
		.fetch_en(fetch_en),
		.branch(branch),
		.branch_target(branch_target),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_valid(instr_valid)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cyc <= cyc + 1;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
		end
		return r;
	endfunction

	// word-aligned target in the lower half of memory
	function automatic cpu_types_pkg::addr_t rand_target();
		return cpu_types_pkg::addr_t'(rand_bits(9)) << 2;
	endfunction

	// expected instruction at a pc, from the loaded copy
	function automatic cpu_types_pkg::word_t expected_instr(input cpu_types_pkg::addr_t pc);
		return prog[(pc >> 2) % cache_cfg_pkg::MEM_WORDS];
	endfunction

	task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		n_checks++;
		if (exp_v !== act_v) begin
			n_err++;
			$display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
		end
	endtask

	// compare every delivered instruction with the pc rules
	always @(posedge CLK) begin
		if (nRST) begin
			if (instr_valid) begin
				check({cur_test, " pc"}, exp_pc, instr_pc);
				check({cur_test, " instr"}, expected_instr(exp_pc), instr);
				n_valid <= n_valid + 1;
				// target of a redirect just arrived
				if (tgt_next) begin
					n_redir <= n_redir + 1;
					tgt_next = 1'b0;
				end
				// one instruction of the old path, then the target
				if (pend) begin
					exp_pc = pend_target;
					pend = 1'b0;
					tgt_next = 1'b1;
				end else begin
					exp_pc = exp_pc + 4;
				end
			end
			if (branch) begin
				pend = 1'b1;
				pend_target = branch_target;
			end
		end
	end

	task automatic load_program();
		for (int i = 0; i < cache_cfg_pkg::MEM_WORDS; i++) begin
			prog[i] = rand_bits(32);
			load_en <= 1'b1;
			load_addr <= cpu_types_pkg::addr_t'(i) << 2;
			load_data <= prog[i];
			@(posedge CLK);
		end
		load_en <= 1'b0;
		@(posedge CLK);
	endtask

	// one-cycle branch pulse
	task automatic do_branch(input cpu_types_pkg::addr_t target);
		branch <= 1'b1;
		branch_target <= target;
		@(posedge CLK);
		branch <= 1'b0;
	endtask

	task automatic wait_valids(input int n);
		int tgt;
		int cycles;
		tgt = n_valid + n;
		cycles = 0;
		while (!abort && n_valid < tgt) begin
			@(posedge CLK);
			cycles++;
			if (cycles > n * WAIT_PER + 20) begin
				$display("timeout in %s: instructions stopped arriving", cur_test);
				n_err++;
				abort = 1'b1;
			end
		end
	endtask

	task automatic wait_redir();
		int tgt;
		int cycles;
		tgt = n_redir + 1;
		cycles = 0;
		while (!abort && n_redir < tgt) begin
			@(posedge CLK);
			cycles++;
			if (cycles > 4 * WAIT_PER + 20) begin
				$display("timeout in %s: branch target was never delivered", cur_test);
				n_err++;
				abort = 1'b1;
			end
		end
	endtask

	task automatic end_test(input int errs_at_start);
		$display("test %-12s finished, %0d error(s)", cur_test, n_err - errs_at_start);
	endtask

	initial begin
		int e0;
		int t0;
		int base;
		cpu_types_pkg::addr_t tgt;
		nRST = 1'b0;
		fetch_en = 1'b0;
		branch = 1'b0;
		branch_target = '0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		repeat (16) @(posedge CLK);
		nRST <= 1'b1;

		// idle after reset, nothing delivered
		e0 = n_err;
		for (int i = 0; i < 12; i++) begin
			@(posedge CLK);
			check("reset valid", 32'd0, 32'(instr_valid));
		end
		end_test(e0);

		load_program();

		// cold stream from the reset pc
		cur_test = "cold_fetch";
		e0 = n_err;
		fetch_en <= 1'b1;
		wait_valids(32);
		end_test(e0);

		// refill 0..60, then a pass that should hit from 4 on
		cur_test = "second_pass";
		e0 = n_err;
		do_branch('0);
		wait_redir();
		wait_valids(15);
		// 64 is missing now, branch lands while it is outstanding
		do_branch('0);
		wait_redir();
		t0 = cyc;
		wait_valids(15);
		check("second_pass hit rate", 32'd1, 32'(cyc - t0 <= 30));
		end_test(e0);

		// random redirects, some right after a miss starts
		cur_test = "branches";
		e0 = n_err;
		for (int i = 0; i < 8; i++) begin
			wait_valids(i % 3);
			do_branch(rand_target());
			wait_redir();
		end
		end_test(e0);

		// same index, different tag
		cur_test = "conflict";
		e0 = n_err;
		tgt = rand_target();
		for (int i = 0; i < 4; i++) begin
			do_branch(tgt);
			wait_redir();
			do_branch(tgt + cpu_types_pkg::addr_t'(SET_STRIDE));
			wait_redir();
		end
		end_test(e0);

		// stop mid-stream, then resume at the next pc
		cur_test = "fetch_stop";
		e0 = n_err;
		fetch_en <= 1'b0;
		repeat (2) @(posedge CLK);
		base = n_valid;
		repeat (3 * WAIT_PER) @(posedge CLK);
		check("fetch_stop extra", 32'd1, 32'(n_valid - base <= 1));
		base = n_valid;
		repeat (3 * WAIT_PER) @(posedge CLK);
		check("fetch_stop idle", 32'd0, 32'(n_valid - base));
		fetch_en <= 1'b1;
		wait_valids(4);
		fetch_en <= 1'b0;
		end_test(e0);

		$display("checks %0d, errors %0d", n_checks, n_err);
		if (n_err == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/cpu_types_pkg.sv
rtl/cache_cfg_pkg.sv
rtl/datapath_cache_if.sv
rtl/caches_if.sv
rtl/fetch_unit.sv
rtl/icache.sv
rtl/instr_mem.sv
rtl/fetch_top.sv
tests/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the instruction fetch testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module fetch_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vfetch_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the printed result line
if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
